//--- project.f
mbus_bridge_pkg.sv
bus_clk_divider.sv
host_frame_parser.sv
host_frame_writer.sv
bridge_control.sv
mbus_bridge_top.sv
tb_mbus_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_mbus_bridge -o tb_mbus_bridge > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_mbus_bridge > sim.log 2>&1
grep -q "TEST PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- tb_mbus_bridge.sv
`timescale 1ns/1ns
module tb_mbus_bridge;
	import mbus_bridge_pkg::*;

	localparam int         CLK_DIV_WIDTH = 22;
	localparam logic [7:0] FLAG_CHAR     = 8'h62;
	localparam int         TIMEOUT       = 200;
	localparam int         NUM_CASES     = 10;

	typedef enum logic [1:0] {
		K_RX,
		K_TX,
		K_BAD,
		K_RX_FAIL
	} kind_t;

	// One stimulus row
	// For bad frames words counts the data bytes
	typedef struct packed {
		kind_t       kind;
		logic [31:0] addr;
		logic [3:0]  words;
		logic        flag;
		logic [7:0]  first;
	} case_t;

	logic                     clk;
	logic                     reset;
	logic [CLK_DIV_WIDTH-1:0] mbus_clk_div;
	host_byte_t               host_in;
	logic                     host_in_strobe;
	host_byte_t               host_out;
	logic                     host_out_strobe;
	logic [7:0]               time_tag;
	logic                     tag_incr;
	bus_rx_word_t             rx_word;
	logic                     rx_req;
	logic                     rx_fail;
	logic                     rx_ack;
	bus_tx_word_t             tx_word;
	logic                     tx_req;
	logic                     tx_ack;
	logic                     tx_succ;
	logic                     tx_fail;
	logic                     bus_clk;

	case_t       cases [NUM_CASES];
	logic [31:0] rng;
	host_byte_t  exp_q[$];

	// Collected by the output monitor
	host_byte_t host_q[$];
	int         cycle        = 0;
	int         tag_count    = 0;
	int         rx_ack_count = 0;
	int         tx_req_count = 0;
	logic       tx_req_prev  = 1'b0;

	mbus_bridge_top #(
		.CLK_DIV_WIDTH(CLK_DIV_WIDTH),
		.FLAG_CHAR    (FLAG_CHAR)
	) UUT (
		.clk            (clk),
		.reset          (reset),
		.mbus_clk_div   (mbus_clk_div),
		.host_in        (host_in),
		.host_in_strobe (host_in_strobe),
		.host_out       (host_out),
		.host_out_strobe(host_out_strobe),
		.time_tag       (time_tag),
		.tag_incr       (tag_incr),
		.rx_word        (rx_word),
		.rx_req         (rx_req),
		.rx_fail        (rx_fail),
		.rx_ack         (rx_ack),
		.tx_word        (tx_word),
		.tx_req         (tx_req),
		.tx_ack         (tx_ack),
		.tx_succ        (tx_succ),
		.tx_fail        (tx_fail),
		.bus_clk        (bus_clk)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Values seen here are the ones held through the cycle before the edge
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (!reset) begin
			if (host_out_strobe)
				host_q.push_back(host_out);
			if (tag_incr) begin
				tag_count = tag_count + 1;
				// Time tag byte goes out in the same cycle
				check_bit("host_out_strobe", host_out_strobe, 1'b1);
				check_host_byte("host_out", host_out, {1'b0, time_tag});
			end
			if (rx_ack)
				rx_ack_count = rx_ack_count + 1;
			if (tx_req && !tx_req_prev)
				tx_req_count = tx_req_count + 1;
		end
		tx_req_prev = tx_req;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_host_byte(input string name, input host_byte_t got,
			input host_byte_t exp);
		if (got !== exp) begin
			$display("Mismatch %s got %h expected %h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_tx_word(input string name, input bus_tx_word_t got,
			input bus_tx_word_t exp);
		if (got !== exp) begin
			$display("Mismatch %s got %h expected %h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s got %h expected %h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Mismatch %s got %h expected %h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic load_cases();
		cases[0] = '{K_TX,      32'hA000_0010, 4'd1, 1'b0, ACK_CHAR};
		cases[1] = '{K_TX,      32'h0000_0F24, 4'd2, 1'b1, NAK_CHAR};
		cases[2] = '{K_TX,      32'h1234_5678, 4'd3, 1'b0, ACK_CHAR};
		cases[3] = '{K_BAD,     32'h0000_0042, 4'd0, 1'b0, NAK_CHAR};
		cases[4] = '{K_BAD,     32'h0000_0043, 4'd2, 1'b0, NAK_CHAR};
		cases[5] = '{K_RX,      32'hF000_0001, 4'd1, 1'b0, FLAG_CHAR};
		cases[6] = '{K_RX,      32'h0000_0A5C, 4'd3, 1'b1, FLAG_CHAR};
		cases[7] = '{K_RX,      32'h0000_0B00, 4'd2, 1'b0, FLAG_CHAR};
		cases[8] = '{K_RX_FAIL, 32'h0000_0C11, 4'd2, 1'b1, FLAG_CHAR};
		// Fail with no message open
		cases[9] = '{K_RX_FAIL, 32'h0000_0000, 4'd0, 1'b0, 8'h00};
	endtask

	task automatic send_host_byte(input logic [7:0] data, input logic last);
		host_in.data   = data;
		host_in.last   = last;
		host_in_strobe = 1'b1;
		@(negedge clk);
		host_in_strobe = 1'b0;
		host_in.last   = 1'b0;
	endtask

	// Most significant byte first
	task automatic send_word32(input logic [31:0] w, input logic last);
		for (int i = 3; i >= 0; i--)
			send_host_byte(w[8*i +: 8], last && (i == 0));
	endtask

	task automatic expect_byte(input logic [7:0] data, input logic last);
		host_byte_t b;
		b.data = data;
		b.last = last;
		exp_q.push_back(b);
	endtask

	task automatic expect_word(input logic [31:0] w);
		for (int i = 3; i >= 0; i--)
			expect_byte(w[8*i +: 8], 1'b0);
	endtask

	task automatic serve_tx_word(input bus_tx_word_t exp);
		int n;
		n = 0;
		while (!tx_req && n < TIMEOUT) begin
			@(negedge clk);
			n = n + 1;
		end
		if (!tx_req)
			fail_now("Timeout waiting for tx_req from the bridge");
		check_tx_word("tx_word", tx_word, exp);
		repeat (3) @(negedge clk);
		check_bit("tx_req", tx_req, 1'b1);
		check_tx_word("tx_word", tx_word, exp);
		tx_ack = 1'b1;
		@(negedge clk);
		tx_ack = 1'b0;
		check_bit("tx_req", tx_req, 1'b0);
	endtask

	task automatic pulse_tx_result(input logic fail);
		tx_succ = !fail;
		tx_fail = fail;
		@(negedge clk);
		tx_succ = 1'b0;
		tx_fail = 1'b0;
	endtask

	task automatic present_rx_word(input bus_rx_word_t w);
		int n;
		n = 0;
		rx_word = w;
		rx_req  = 1'b1;
		while (!rx_ack && n < TIMEOUT) begin
			@(negedge clk);
			n = n + 1;
		end
		if (!rx_ack)
			fail_now("Timeout waiting for rx_ack on a bus receive word");
		rx_req = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic pulse_rx_fail();
		int n;
		n = 0;
		rx_fail = 1'b1;
		@(negedge clk);
		rx_fail = 1'b0;
		while (!rx_ack && n < TIMEOUT) begin
			@(negedge clk);
			n = n + 1;
		end
		if (!rx_ack)
			fail_now("Timeout waiting for rx_ack after rx_fail");
	endtask

	task automatic wait_host_bytes(input int count);
		int n;
		n = 0;
		while (host_q.size() < count && n < TIMEOUT) begin
			@(negedge clk);
			n = n + 1;
		end
		if (host_q.size() < count)
			fail_now("Timeout waiting for the host output frame");
	endtask

	task automatic compare_frame(input int base);
		check_count("host_out byte count", host_q.size() - base, exp_q.size());
		foreach (exp_q[i])
			check_host_byte($sformatf("host_out[%0d]", i), host_q[base + i], exp_q[i]);
	endtask

	// Half period of bus_clk is the divider value plus one
	task automatic check_bus_clk_period();
		logic prev;
		int   last_edge;
		int   edges;
		int   n;
		prev      = bus_clk;
		last_edge = 0;
		edges     = 0;
		n         = 0;
		while (edges < 4 && n < TIMEOUT) begin
			@(negedge clk);
			n = n + 1;
			if (bus_clk !== prev) begin
				if (edges > 0)
					check_count("bus_clk half period", cycle - last_edge,
						int'(mbus_clk_div) + 1);
				last_edge = cycle;
				edges     = edges + 1;
				prev      = bus_clk;
			end
		end
		if (edges < 4)
			fail_now("Timeout waiting for bus_clk edges");
	endtask

	task automatic run_case(input int idx, input case_t c);
		bus_tx_word_t txw;
		bus_rx_word_t rxw;
		logic [7:0]   eid;
		logic         bcast;
		logic         fail;
		int           nw;
		int           base;
		int           tags;
		int           acks;
		int           reqs;

		nw    = int'(c.words);
		base  = host_q.size();
		tags  = tag_count;
		acks  = rx_ack_count;
		reqs  = tx_req_count;
		eid   = 8'h20 + 8'(idx);
		bcast = 1'b0;
		fail  = (c.kind == K_RX_FAIL);
		exp_q.delete();
		case (c.kind)
			K_TX: begin
				send_host_byte(eid, 1'b0);
				send_word32(c.addr, 1'b0);
				for (int k = 0; k < nw; k++) begin
					rng = xorshift32(rng);
					send_word32(rng, k == nw - 1);
					txw.addr = c.addr;
					txw.data = rng;
					txw.pend = (k != nw - 1);
					serve_tx_word(txw);
				end
				pulse_tx_result(c.flag);
				expect_byte(c.first, 1'b0);
				expect_byte(eid, 1'b0);
				expect_byte(8'h00, 1'b1);
			end
			K_BAD: begin
				send_host_byte(eid, 1'b0);
				send_word32(c.addr, nw == 0);
				for (int k = 0; k < nw; k++)
					send_host_byte(8'hC0 + 8'(k), k == nw - 1);
				expect_byte(c.first, 1'b0);
				expect_byte(eid, 1'b0);
				expect_byte(8'h00, 1'b1);
			end
			default: begin
				time_tag = time_tag + 8'h11;
				if (nw > 0) begin
					expect_byte(c.first, 1'b0);
					expect_byte(time_tag, 1'b0);
					expect_word(c.addr);
				end
				for (int k = 0; k < nw; k++) begin
					rng           = xorshift32(rng);
					rxw.addr      = c.addr;
					rxw.data      = rng;
					// Broadcast on an early word, later words clear
					rxw.broadcast = c.flag && (k == (nw - 1) / 2);
					// A failing message never delivers its closing word
					rxw.pend      = fail || (k != nw - 1);
					bcast         = bcast | rxw.broadcast;
					expect_word(rng);
					present_rx_word(rxw);
				end
				if (fail)
					pulse_rx_fail();
				if (nw > 0)
					expect_byte({6'd0, fail, bcast}, 1'b1);
			end
		endcase
		if (exp_q.size() > 0)
			wait_host_bytes(base + exp_q.size());
		repeat (20) @(negedge clk);
		compare_frame(base);
		check_count("tx_req count", tx_req_count - reqs, (c.kind == K_TX) ? nw : 0);
		check_count("rx_ack count", rx_ack_count - acks,
			(c.kind == K_RX || fail) ? nw + int'(fail) : 0);
		check_count("tag_incr count", tag_count - tags,
			(c.kind == K_RX || fail) && nw > 0 ? 1 : 0);
	endtask

	initial begin
		reset          = 1'b1;
		mbus_clk_div   = 3;
		host_in        = '0;
		host_in_strobe = 1'b0;
		time_tag       = 8'h40;
		rx_word        = '0;
		rx_req         = 1'b0;
		rx_fail        = 1'b0;
		tx_ack         = 1'b0;
		tx_succ        = 1'b0;
		tx_fail        = 1'b0;
		rng            = 32'd42;
		load_cases();
		repeat (10) @(negedge clk);
		check_bit("host_out_strobe", host_out_strobe, 1'b0);
		check_bit("tx_req", tx_req, 1'b0);
		check_bit("rx_ack", rx_ack, 1'b0);
		check_bit("tag_incr", tag_incr, 1'b0);
		check_bit("bus_clk", bus_clk, 1'b0);
		reset = 1'b0;
		check_bus_clk_period();
		for (int i = 0; i < NUM_CASES; i++)
			run_case(i, cases[i]);
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- mbus_bridge_top.sv
`timescale 1ns/1ns
module mbus_bridge_top #(
	parameter int         CLK_DIV_WIDTH = 22,
	parameter logic [7:0] FLAG_CHAR     = 8'h62
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [CLK_DIV_WIDTH-1:0]      mbus_clk_div,
	input  mbus_bridge_pkg::host_byte_t   host_in,
	input  logic                          host_in_strobe,
	output mbus_bridge_pkg::host_byte_t   host_out,
	output logic                          host_out_strobe,
	input  logic [7:0]                    time_tag,
	output logic                          tag_incr,
	input  mbus_bridge_pkg::bus_rx_word_t rx_word,
	input  logic                          rx_req,
	input  logic                          rx_fail,
	output logic                          rx_ack,
	output mbus_bridge_pkg::bus_tx_word_t tx_word,
	output logic                          tx_req,
	input  logic                          tx_ack,
	input  logic                          tx_succ,
	input  logic                          tx_fail,
	output logic                          bus_clk
);
	import mbus_bridge_pkg::*;

	writer_cmd_t cmd;
	logic        word_ready;
	logic        bad_frame;
	logic        word_taken;
	logic        rx_fail_seen;
	logic        writer_busy;
	logic [7:0]  eid;

	bus_clk_divider #(
		.CLK_DIV_WIDTH(CLK_DIV_WIDTH)
	) u_clk_div (
		.clk    (clk),
		.reset  (reset),
		.div    (mbus_clk_div),
		.bus_clk(bus_clk)
	);

	// Host to bus path
	host_frame_parser u_parser (
		.clk           (clk),
		.reset         (reset),
		.host_in       (host_in),
		.host_in_strobe(host_in_strobe),
		.word_taken    (word_taken),
		.word_ready    (word_ready),
		.bad_frame     (bad_frame),
		.tx_word       (tx_word),
		.eid           (eid)
	);

	// Bus to host path and replies
	host_frame_writer #(
		.FLAG_CHAR(FLAG_CHAR)
	) u_writer (
		.clk            (clk),
		.reset          (reset),
		.cmd            (cmd),
		.rx_word        (rx_word),
		.rx_fail_seen   (rx_fail_seen),
		.eid            (eid),
		.time_tag       (time_tag),
		.host_out       (host_out),
		.host_out_strobe(host_out_strobe),
		.tag_incr       (tag_incr),
		.writer_busy    (writer_busy)
	);

	bridge_control u_control (
		.clk         (clk),
		.reset       (reset),
		.rx_req      (rx_req),
		.rx_fail     (rx_fail),
		.rx_word_pend(rx_word.pend),
		.word_ready  (word_ready),
		.bad_frame   (bad_frame),
		.tx_ack      (tx_ack),
		.tx_succ     (tx_succ),
		.tx_fail     (tx_fail),
		.writer_busy (writer_busy),
		.rx_ack      (rx_ack),
		.tx_req      (tx_req),
		.word_taken  (word_taken),
		.rx_fail_seen(rx_fail_seen),
		.cmd         (cmd)
	);

endmodule

//--- bridge_control.sv
`timescale 1ns/1ns
module bridge_control (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         rx_req,
	input  logic                         rx_fail,
	input  logic                         rx_word_pend,
	input  logic                         word_ready,
	input  logic                         bad_frame,
	input  logic                         tx_ack,
	input  logic                         tx_succ,
	input  logic                         tx_fail,
	input  logic                         writer_busy,
	output logic                         rx_ack,
	output logic                         tx_req,
	output logic                         word_taken,
	output logic                         rx_fail_seen,
	output mbus_bridge_pkg::writer_cmd_t cmd
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_RX_HEADER,
		S_RX_DRAIN,
		S_RX_WAIT_NEXT,
		S_RX_CLOSE,
		S_TX_SEND,
		S_TX_WAIT_RESULT,
		S_REPLY
	} state_t;

	state_t     state;
	state_t     state_n;
	logic [1:0] rx_req_sync;
	logic [1:0] rx_fail_sync;
	logic       rx_fail_prev;
	logic       rx_req_s;
	logic       rx_fail_edge;
	// Events held until the FSM can serve them
	logic       fail_evt;
	logic       word_avail;
	logic       bad_pend;
	logic       more_words;
	logic       ack_rx;
	logic       take_fail;
	logic       take_word;
	logic       take_bad;
	logic       set_fail_seen;
	logic       raise_tx;

	assign rx_req_s     = rx_req_sync[1];
	assign rx_fail_edge = rx_fail_sync[1] && !rx_fail_prev;
	assign word_taken   = (state == S_TX_SEND) && tx_ack;

	always_comb begin
		state_n       = state;
		cmd           = '0;
		ack_rx        = 1'b0;
		take_fail     = 1'b0;
		take_word     = 1'b0;
		take_bad      = 1'b0;
		set_fail_seen = 1'b0;
		raise_tx      = 1'b0;
		case (state)
			S_IDLE: begin
				// Bus receive goes ahead of host transmit
				if (rx_req_s) begin
					cmd.start_rx = 1'b1;
					ack_rx       = 1'b1;
					state_n      = S_RX_HEADER;
				end else if (fail_evt) begin
					ack_rx    = 1'b1;
					take_fail = 1'b1;
				end else if (word_avail) begin
					raise_tx  = 1'b1;
					take_word = 1'b1;
					state_n   = S_TX_SEND;
				end else if (bad_pend) begin
					cmd.send_nak = 1'b1;
					take_bad     = 1'b1;
					state_n      = S_REPLY;
				end
			end
			S_RX_HEADER: begin
				// Wait out the request drop through the synchronizer
				if (!rx_req_s)
					state_n = S_RX_DRAIN;
			end
			S_RX_DRAIN: begin
				if (!writer_busy)
					state_n = more_words ? S_RX_WAIT_NEXT : S_RX_CLOSE;
			end
			S_RX_WAIT_NEXT: begin
				if (rx_req_s) begin
					cmd.next_word = 1'b1;
					ack_rx        = 1'b1;
					state_n       = S_RX_HEADER;
				end else if (fail_evt) begin
					ack_rx        = 1'b1;
					take_fail     = 1'b1;
					set_fail_seen = 1'b1;
					state_n       = S_RX_CLOSE;
				end
			end
			S_RX_CLOSE: begin
				cmd.finish_rx = 1'b1;
				state_n       = S_REPLY;
			end
			S_TX_SEND: begin
				if (tx_ack)
					state_n = S_TX_WAIT_RESULT;
			end
			S_TX_WAIT_RESULT: begin
				// Either the result or the next word of the same frame
				if (tx_succ) begin
					cmd.send_ack = 1'b1;
					state_n      = S_REPLY;
				end else if (tx_fail) begin
					cmd.send_nak = 1'b1;
					state_n      = S_REPLY;
				end else if (word_avail) begin
					raise_tx  = 1'b1;
					take_word = 1'b1;
					state_n   = S_TX_SEND;
				end else if (bad_pend) begin
					cmd.send_nak = 1'b1;
					take_bad     = 1'b1;
					state_n      = S_REPLY;
				end
			end
			S_REPLY: begin
				if (!writer_busy)
					state_n = S_IDLE;
			end
			default: state_n = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= S_IDLE;
			rx_req_sync  <= 2'b00;
			rx_fail_sync <= 2'b00;
			rx_fail_prev <= 1'b0;
			fail_evt     <= 1'b0;
			word_avail   <= 1'b0;
			bad_pend     <= 1'b0;
			more_words   <= 1'b0;
			rx_ack       <= 1'b0;
			tx_req       <= 1'b0;
			rx_fail_seen <= 1'b0;
		end else begin
			state        <= state_n;
			rx_req_sync  <= {rx_req_sync[0], rx_req};
			rx_fail_sync <= {rx_fail_sync[0], rx_fail};
			rx_fail_prev <= rx_fail_sync[1];
			fail_evt     <= rx_fail_edge || (fail_evt && !take_fail);
			word_avail   <= word_ready || (word_avail && !take_word);
			bad_pend     <= bad_frame || (bad_pend && !take_bad);
			// Writer has the word by the time the bus sees the ack
			rx_ack       <= ack_rx;
			if (ack_rx)
				more_words <= rx_word_pend;
			if (raise_tx)
				tx_req <= 1'b1;
			else if (word_taken)
				tx_req <= 1'b0;
			if (cmd.start_rx)
				rx_fail_seen <= 1'b0;
			else if (set_fail_seen)
				rx_fail_seen <= 1'b1;
		end
	end

	a_ack_without_req: assert property (
		@(posedge clk) disable iff (reset)
		tx_ack |-> tx_req
	) else $error("bus tx_ack seen with no tx_req outstanding");

endmodule

//--- host_frame_writer.sv
`timescale 1ns/1ns
module host_frame_writer #(
	parameter logic [7:0] FLAG_CHAR = 8'h62
) (
	input  logic                          clk,
	input  logic                          reset,
	input  mbus_bridge_pkg::writer_cmd_t  cmd,
	input  mbus_bridge_pkg::bus_rx_word_t rx_word,
	input  logic                          rx_fail_seen,
	input  logic [7:0]                    eid,
	input  logic [7:0]                    time_tag,
	output mbus_bridge_pkg::host_byte_t   host_out,
	output logic                          host_out_strobe,
	output logic                          tag_incr,
	output logic                          writer_busy
);
	import mbus_bridge_pkg::*;

	// Byte to be produced on the next cycle
	typedef enum logic [2:0] {
		P_IDLE,
		P_TAG,
		P_DATA,
		P_EID,
		P_ZERO
	} phase_t;

	phase_t      phase;
	logic [63:0] data_sr;
	logic [3:0]  bytes_left;
	logic        bcast_acc;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase           <= P_IDLE;
			host_out_strobe <= 1'b0;
			tag_incr        <= 1'b0;
			bytes_left      <= 4'd0;
			bcast_acc       <= 1'b0;
		end else begin
			host_out_strobe <= 1'b0;
			tag_incr        <= 1'b0;
			if (cmd.start_rx) begin
				host_out_strobe <= 1'b1;
				phase           <= P_TAG;
				// Address and data of the first word
				bytes_left      <= 4'd8;
				bcast_acc       <= rx_word.broadcast;
			end else if (cmd.next_word) begin
				host_out_strobe <= 1'b1;
				phase           <= P_DATA;
				bytes_left      <= 4'd3;
				bcast_acc       <= bcast_acc | rx_word.broadcast;
			end else if (cmd.finish_rx) begin
				host_out_strobe <= 1'b1;
			end else if (cmd.send_ack || cmd.send_nak) begin
				host_out_strobe <= 1'b1;
				phase           <= P_EID;
			end else begin
				case (phase)
					P_TAG: begin
						host_out_strobe <= 1'b1;
						tag_incr        <= 1'b1;
						phase           <= P_DATA;
					end
					P_DATA: begin
						host_out_strobe <= 1'b1;
						bytes_left      <= bytes_left - 4'd1;
						if (bytes_left == 4'd1)
							phase <= P_IDLE;
					end
					P_EID: begin
						host_out_strobe <= 1'b1;
						phase           <= P_ZERO;
					end
					P_ZERO: begin
						host_out_strobe <= 1'b1;
						phase           <= P_IDLE;
					end
					default: ;
				endcase
			end
		end
	end

	// Outgoing byte and the word shift register
	always_ff @(posedge clk) begin
		host_out.last <= 1'b0;
		if (cmd.start_rx) begin
			host_out.data <= FLAG_CHAR;
			data_sr       <= {rx_word.addr, rx_word.data};
		end else if (cmd.next_word) begin
			// Later words carry data bytes only
			host_out.data <= rx_word.data[31:24];
			data_sr       <= {rx_word.data[23:0], 40'd0};
		end else if (cmd.finish_rx) begin
			host_out.data <= {6'd0, rx_fail_seen, bcast_acc};
			host_out.last <= 1'b1;
		end else if (cmd.send_ack) begin
			host_out.data <= ACK_CHAR;
		end else if (cmd.send_nak) begin
			host_out.data <= NAK_CHAR;
		end else begin
			case (phase)
				P_TAG: host_out.data <= time_tag;
				P_DATA: begin
					host_out.data <= data_sr[63:56];
					data_sr       <= {data_sr[55:0], 8'd0};
				end
				P_EID: host_out.data <= eid;
				P_ZERO: begin
					host_out.data <= 8'h00;
					host_out.last <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	// Busy through the cycle of the final byte
	assign writer_busy = host_out_strobe || (phase != P_IDLE);

	a_cmd_while_busy: assert property (
		@(posedge clk) disable iff (reset)
		(cmd != '0) |-> !writer_busy
	) else $error("writer command issued while a frame is still going out");

endmodule

//--- host_frame_parser.sv
`timescale 1ns/1ns
module host_frame_parser (
	input  logic                          clk,
	input  logic                          reset,
	input  mbus_bridge_pkg::host_byte_t   host_in,
	input  logic                          host_in_strobe,
	input  logic                          word_taken,
	output logic                          word_ready,
	output logic                          bad_frame,
	output mbus_bridge_pkg::bus_tx_word_t tx_word,
	output logic [7:0]                    eid
);

	// Byte position in the frame, 1 to 4 are address bytes
	localparam logic [2:0] POS_EID  = 3'd0;
	localparam logic [2:0] POS_DATA = 3'd5;

	logic [2:0]  pos;
	logic [1:0]  data_idx;
	logic [31:0] addr_sr;
	logic [23:0] data_sr;
	logic        word_pending;
	logic        word_done;

	// Fourth byte of a data word
	assign word_done = host_in_strobe && (pos == POS_DATA) && (data_idx == 2'd3);

	always_ff @(posedge clk) begin
		if (reset) begin
			pos          <= POS_EID;
			data_idx     <= 2'd0;
			word_pending <= 1'b0;
			word_ready   <= 1'b0;
			bad_frame    <= 1'b0;
		end else begin
			word_ready <= word_done;
			// A good frame ends exactly on a completed word
			bad_frame  <= host_in_strobe && host_in.last && !word_done;

			if (word_done)
				word_pending <= 1'b1;
			else if (word_taken)
				word_pending <= 1'b0;

			if (host_in_strobe) begin
				if (host_in.last) begin
					pos      <= POS_EID;
					data_idx <= 2'd0;
				end else if (pos != POS_DATA) begin
					pos <= pos + 3'd1;
				end else begin
					data_idx <= data_idx + 2'd1;
				end
			end
		end
	end

	// Byte steering into the header and data registers
	always_ff @(posedge clk) begin
		if (host_in_strobe) begin
			case (pos)
				POS_EID:  eid     <= host_in.data;
				POS_DATA: data_sr <= {data_sr[15:0], host_in.data};
				default:  addr_sr <= {addr_sr[23:0], host_in.data};
			endcase
		end
		// Output word held stable until the next word completes
		if (word_done) begin
			tx_word.addr <= addr_sr;
			tx_word.data <= {data_sr, host_in.data};
			tx_word.pend <= !host_in.last;
		end
	end

	// Host must not outrun the bus by a full word
	a_word_overrun: assert property (
		@(posedge clk) disable iff (reset)
		word_done |-> (!word_pending || word_taken)
	) else $error("parser word completed before previous word was taken");

endmodule

//--- bus_clk_divider.sv
`timescale 1ns/1ns
module bus_clk_divider #(
	parameter int CLK_DIV_WIDTH = 22
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [CLK_DIV_WIDTH-1:0] div,
	output logic                     bus_clk
);

	logic [CLK_DIV_WIDTH-1:0] count;
	// Divider value in use for the current half period
	logic [CLK_DIV_WIDTH-1:0] div_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			count   <= '0;
			div_q   <= div;
			bus_clk <= 1'b0;
		end else if (count == div_q) begin
			// Terminal count, toggle and pick up a new divider
			count   <= '0;
			div_q   <= div;
			bus_clk <= ~bus_clk;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

//--- mbus_bridge_pkg.sv
package mbus_bridge_pkg;

	// One character of the host byte stream
	typedef struct packed {
		logic       last;
		logic [7:0] data;
	} host_byte_t;

	// Word handed up by the bus controller on receive
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic        broadcast;
		// More words of the same message follow
		logic        pend;
	} bus_rx_word_t;

	// Word handed down to the bus controller for transmit
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic        pend;
	} bus_tx_word_t;

	// Single-cycle requests from control to the host writer
	typedef struct packed {
		logic start_rx;
		logic next_word;
		logic finish_rx;
		logic send_ack;
		logic send_nak;
	} writer_cmd_t;

	// First byte of the reply frames
	localparam logic [7:0] ACK_CHAR = 8'h61;
	localparam logic [7:0] NAK_CHAR = 8'h6E;

endpackage
